/* verilog/asg_pkg.sv */
// shared widths, channel count and control bit positions
// register opcode and channel state enums

package asg_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  // channel count and trigger sources
  localparam int unsigned NCH = 2;
  localparam int unsigned TN  = 4;
  // pointer, integer and fraction parts
  localparam int unsigned CWM = 8;
  localparam int unsigned CWF = 8;
  localparam int unsigned PW  = CWM + CWF;
  // signed sample
  localparam int unsigned SW  = 12;
  // burst counters
  localparam int unsigned BW  = 16;
  // write bus
  localparam int unsigned AW  = 12;
  localparam int unsigned DW  = 32;

  // mixer sum, wide enough for NCH samples
  localparam int unsigned MXW = SW + $clog2(NCH) + 1;
  // clamp limits
  localparam logic signed [SW-1:0] SMP_MAX = {1'b0, {(SW-1){1'b1}}};
  localparam logic signed [SW-1:0] SMP_MIN = {1'b1, {(SW-1){1'b0}}};

  // REG_CTL bits
  localparam int unsigned CTL_CLR = 0;
  localparam int unsigned CTL_BEN = 1;
  localparam int unsigned CTL_INF = 2;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // opcode in low address bits, register region only
  typedef enum logic [3:0] {
    REG_CTL = 4'h0,
    REG_TRG = 4'h1,
    REG_SIZ = 4'h2,
    REG_STP = 4'h3,
    REG_OFF = 4'h4,
    REG_BDL = 4'h5,
    REG_BIL = 4'h6,
    REG_BNM = 4'h7
  } asg_reg_e;

  // channel run state
  typedef enum logic [1:0] {
    STS_IDL = 2'b00,
    STS_DAT = 2'b01,
    STS_DLY = 2'b10
  } asg_sts_e;

endpackage : asg_pkg

/* verilog/asg_regs.sv */
// write decoder for the channel configuration registers
// table writes are routed through one register stage

module asg_regs (
  input  logic                                          sto,
  input  logic                                          ctl_rst,
  // write-only bus
  input  logic                                          bus_wen,
  input  logic [asg_pkg::AW-1:0]                        bus_addr,
  input  logic [asg_pkg::DW-1:0]                        bus_wdata,
  // per-channel configuration
  output logic [asg_pkg::NCH-1:0][asg_pkg::TN-1:0]      cfg_trg,
  output logic [asg_pkg::NCH-1:0][asg_pkg::PW-1:0]      cfg_siz,
  output logic [asg_pkg::NCH-1:0][asg_pkg::PW-1:0]      cfg_stp,
  output logic [asg_pkg::NCH-1:0][asg_pkg::PW-1:0]      cfg_off,
  output logic [asg_pkg::NCH-1:0]                       cfg_ben,
  output logic [asg_pkg::NCH-1:0]                       cfg_inf,
  output logic [asg_pkg::NCH-1:0][asg_pkg::BW-1:0]      cfg_bdl,
  output logic [asg_pkg::NCH-1:0][asg_pkg::BW-1:0]      cfg_bil,
  output logic [asg_pkg::NCH-1:0][asg_pkg::BW-1:0]      cfg_bnm,
  output logic [asg_pkg::NCH-1:0]                       clr,
  // table write port per channel
  output logic [asg_pkg::NCH-1:0]                       tbl_wen,
  output logic [asg_pkg::NCH-1:0][asg_pkg::CWM-1:0]     tbl_addr,
  output logic [asg_pkg::NCH-1:0][asg_pkg::SW-1:0]      tbl_dat
);

  import asg_pkg::*;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  logic           wr_ch;
  logic           wr_tbl;
  asg_reg_e       wr_opc;
  logic [NCH-1:0] wr_sel;

  // bit 11 channel, bit 10 table region
  assign wr_ch  = bus_addr[AW-1];
  assign wr_tbl = bus_addr[AW-2];
  assign wr_opc = asg_reg_e'(bus_addr[3:0]);
  // one-hot channel select, only during the strobe
  assign wr_sel = {NCH{bus_wen}} & (NCH'(1) << wr_ch);

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      cfg_trg  <= '0;
      cfg_siz  <= '0;
      cfg_stp  <= '0;
      cfg_off  <= '0;
      cfg_ben  <= '0;
      cfg_inf  <= '0;
      cfg_bdl  <= '0;
      cfg_bil  <= '0;
      cfg_bnm  <= '0;
      clr      <= '0;
      tbl_wen  <= '0;
      tbl_addr <= '0;
      tbl_dat  <= '0;
    end else begin
      for (int i = 0; i < NCH; i++) begin
        // clear pulse, one cycle
        clr[i] <= wr_sel[i] & ~wr_tbl & (wr_opc == REG_CTL) & bus_wdata[CTL_CLR];
        // table write, delayed one stage
        tbl_wen[i] <= wr_sel[i] & wr_tbl;
        if (wr_sel[i] & wr_tbl) begin
          tbl_addr[i] <= bus_addr[CWM-1:0];
          tbl_dat[i]  <= bus_wdata[SW-1:0];
        end
        // config by opcode
        if (wr_sel[i] & ~wr_tbl) begin
          case (wr_opc)
            REG_CTL: begin
              cfg_ben[i] <= bus_wdata[CTL_BEN];
              cfg_inf[i] <= bus_wdata[CTL_INF];
            end
            REG_TRG: cfg_trg[i] <= bus_wdata[TN-1:0];
            REG_SIZ: cfg_siz[i] <= bus_wdata[PW-1:0];
            REG_STP: cfg_stp[i] <= bus_wdata[PW-1:0];
            REG_OFF: cfg_off[i] <= bus_wdata[PW-1:0];
            REG_BDL: cfg_bdl[i] <= bus_wdata[BW-1:0];
            REG_BIL: cfg_bil[i] <= bus_wdata[BW-1:0];
            REG_BNM: cfg_bnm[i] <= bus_wdata[BW-1:0];
            default: ;
          endcase
        end
      end
    end
  end

endmodule : asg_regs

/* verilog/asg_channel.sv */
// one generator channel: waveform table, fixed-point read pointer,
// burst state machine and sample strobe

module asg_channel (
  input  logic                         sto,
  input  logic                         ctl_rst,
  input  logic                         clr,
  // trigger lines and mask
  input  logic [asg_pkg::TN-1:0]       trg,
  input  logic [asg_pkg::TN-1:0]       cfg_trg,
  // pointer config, fixed point
  input  logic [asg_pkg::PW-1:0]       cfg_siz,
  input  logic [asg_pkg::PW-1:0]       cfg_stp,
  input  logic [asg_pkg::PW-1:0]       cfg_off,
  // burst config
  input  logic                         cfg_ben,
  input  logic                         cfg_inf,
  input  logic [asg_pkg::BW-1:0]       cfg_bdl,
  input  logic [asg_pkg::BW-1:0]       cfg_bil,
  input  logic [asg_pkg::BW-1:0]       cfg_bnm,
  // table write
  input  logic                         tbl_wen,
  input  logic [asg_pkg::CWM-1:0]      tbl_addr,
  input  logic [asg_pkg::SW-1:0]       tbl_dat,
  // sample out
  output logic signed [asg_pkg::SW-1:0] smp,
  output logic                         smp_vld,
  output logic                         evt
);

  import asg_pkg::*;

  // table and read path
  logic signed [SW-1:0] tbl_mem [2**CWM];
  logic        [CWM-1:0] buf_radr;
  logic signed [SW-1:0] buf_rdat;
  // pointer, one extra bit for the wrap test
  logic [PW-1:0] ptr_cur;
  logic [PW:0]   ptr_nxt;
  logic [PW:0]   ptr_sub;
  logic          ptr_neg;
  // burst counters
  logic [BW-1:0] cnt_cyc;
  logic [BW-1:0] cnt_dly;
  logic [BW-1:0] cnt_rep;
  // state and events
  asg_sts_e sts_run;
  asg_sts_e sts_vld;
  logic     trg_msk;
  logic     sts_beg;
  logic     sts_end;
  logic     sts_rpt;
  logic     sts_trg;
  logic     sts_clr;

  assign sts_clr = ctl_rst | clr;

  ////////////////////////////////////////////////////////////
  // table
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (tbl_wen) begin
      tbl_mem[tbl_addr] <= tbl_dat;
    end
  end

  // two read stages: address, then data
  always_ff @(posedge sto) begin
    if (sts_run == STS_DAT) begin
      buf_radr <= ptr_cur[CWF+:CWM];
    end
    if (sts_vld == STS_DAT) begin
      buf_rdat <= tbl_mem[buf_radr];
    end
  end

  ////////////////////////////////////////////////////////////
  // burst state machine
  ////////////////////////////////////////////////////////////

  // masked trigger only counts from idle
  assign trg_msk = |(trg & cfg_trg);
  assign sts_beg = trg_msk & (sts_run == STS_IDL);
  // both counters spent
  assign sts_end = cfg_ben & (sts_run != STS_IDL) & ~|cnt_cyc & ~|cnt_dly;
  // another repetition pending
  assign sts_rpt = sts_end & (cfg_inf | (cnt_rep > BW'(1)));
  assign sts_trg = sts_beg | sts_rpt;

  always_ff @(posedge sto) begin
    if (sts_clr) begin
      sts_run <= STS_IDL;
      cnt_cyc <= '0;
      cnt_dly <= '0;
      cnt_rep <= '0;
    end else if (sts_trg) begin
      sts_run <= STS_DAT;
      cnt_cyc <= cfg_bdl;
      cnt_dly <= cfg_bil;
      // first start loads the count, infinite never counts down
      if (sts_beg) begin
        cnt_rep <= cfg_bnm;
      end else if (!cfg_inf) begin
        cnt_rep <= cnt_rep - BW'(1);
      end
    end else if (sts_end) begin
      // last repetition done
      sts_run <= STS_IDL;
      cnt_rep <= '0;
    end else if (cfg_ben) begin
      if ((sts_run == STS_DAT) && (cnt_cyc == '0) && (cnt_dly != '0)) begin
        sts_run <= STS_DLY;
      end
      if ((sts_run == STS_DAT) && (cnt_cyc != '0)) begin
        cnt_cyc <= cnt_cyc - BW'(1);
      end
      if ((sts_run == STS_DLY) && (cnt_dly != '0)) begin
        cnt_dly <= cnt_dly - BW'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read pointer
  ////////////////////////////////////////////////////////////

  // step, then try to wrap by size+1
  assign ptr_nxt = {1'b0, ptr_cur} + {1'b0, cfg_stp};
  assign ptr_sub = ptr_nxt - {1'b0, cfg_siz} - (PW+1)'(1);
  assign ptr_neg = ptr_sub[PW];

  always_ff @(posedge sto) begin
    if (sts_clr) begin
      ptr_cur <= '0;
    end else if (sts_trg) begin
      // phase comes from the offset
      ptr_cur <= cfg_off;
    end else if (sts_run == STS_DAT) begin
      ptr_cur <= ptr_neg ? ptr_nxt[PW-1:0] : ptr_sub[PW-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // strobes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (sts_clr) begin
      sts_vld <= STS_IDL;
      smp_vld <= 1'b0;
      evt     <= 1'b0;
    end else begin
      // follows the read pipe, idle cycles are not valid
      sts_vld <= sts_run;
      smp_vld <= (sts_vld == STS_DAT);
      evt     <= sts_trg;
    end
  end

  // invalid sample reads as zero
  assign smp = smp_vld ? buf_rdat : '0;

endmodule : asg_channel

/* verilog/asg_mix.sv */
// saturating sum of the channel samples into one DAC word
// and merged trigger events

module asg_mix (
  input  logic                                    sto,
  input  logic                                    ctl_rst,
  // from channels
  input  logic [asg_pkg::NCH-1:0][asg_pkg::SW-1:0] smp,
  input  logic [asg_pkg::NCH-1:0]                  smp_vld,
  input  logic [asg_pkg::NCH-1:0]                  evt,
  // DAC side
  output logic signed [asg_pkg::SW-1:0]            dac,
  output logic                                     dac_vld,
  output logic                                     trg_out
);

  import asg_pkg::*;

  logic signed [MXW-1:0] sum;
  logic signed [SW-1:0]  sat;

  // sign-extended sum, invalid channels are already zero
  always_comb begin
    sum = '0;
    for (int i = 0; i < NCH; i++) begin
      sum = sum + {{(MXW-SW){smp[i][SW-1]}}, smp[i]};
    end
  end

  // clamp when the upper bits do not match the sign
  always_comb begin
    if (!sum[MXW-1] && (|sum[MXW-2:SW-1])) begin
      sat = SMP_MAX;
    end else if (sum[MXW-1] && !(&sum[MXW-2:SW-1])) begin
      sat = SMP_MIN;
    end else begin
      sat = sum[SW-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // output stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      dac     <= '0;
      dac_vld <= 1'b0;
      trg_out <= 1'b0;
    end else begin
      dac     <= sat;
      dac_vld <= |smp_vld;
      trg_out <= |evt;
    end
  end

endmodule : asg_mix

/* verilog/asg_top.sv */
// generator top: register block, channel array and mixer

module asg_top (
  input  logic                          sto,
  input  logic                          ctl_rst,
  // write bus
  input  logic                          bus_wen,
  input  logic [asg_pkg::AW-1:0]        bus_addr,
  input  logic [asg_pkg::DW-1:0]        bus_wdata,
  // trigger lines
  input  logic [asg_pkg::TN-1:0]        trg,
  // DAC
  output logic signed [asg_pkg::SW-1:0] dac,
  output logic                          dac_vld,
  output logic                          trg_out
);

  import asg_pkg::*;

  // configuration, one slice per channel
  logic [NCH-1:0][TN-1:0]  cfg_trg;
  logic [NCH-1:0][PW-1:0]  cfg_siz;
  logic [NCH-1:0][PW-1:0]  cfg_stp;
  logic [NCH-1:0][PW-1:0]  cfg_off;
  logic [NCH-1:0]          cfg_ben;
  logic [NCH-1:0]          cfg_inf;
  logic [NCH-1:0][BW-1:0]  cfg_bdl;
  logic [NCH-1:0][BW-1:0]  cfg_bil;
  logic [NCH-1:0][BW-1:0]  cfg_bnm;
  logic [NCH-1:0]          clr;
  // table writes
  logic [NCH-1:0]          tbl_wen;
  logic [NCH-1:0][CWM-1:0] tbl_addr;
  logic [NCH-1:0][SW-1:0]  tbl_dat;
  // channel outputs
  logic [NCH-1:0][SW-1:0]  smp;
  logic [NCH-1:0]          smp_vld;
  logic [NCH-1:0]          evt;

  asg_regs u_regs (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .bus_wen   (bus_wen),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .cfg_trg   (cfg_trg),
    .cfg_siz   (cfg_siz),
    .cfg_stp   (cfg_stp),
    .cfg_off   (cfg_off),
    .cfg_ben   (cfg_ben),
    .cfg_inf   (cfg_inf),
    .cfg_bdl   (cfg_bdl),
    .cfg_bil   (cfg_bil),
    .cfg_bnm   (cfg_bnm),
    .clr       (clr),
    .tbl_wen   (tbl_wen),
    .tbl_addr  (tbl_addr),
    .tbl_dat   (tbl_dat)
  );

  ////////////////////////////////////////////////////////////
  // channels
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NCH; i++) begin : g_ch
    asg_channel u_ch (
      .sto      (sto),
      .ctl_rst  (ctl_rst),
      .clr      (clr[i]),
      .trg      (trg),
      .cfg_trg  (cfg_trg[i]),
      .cfg_siz  (cfg_siz[i]),
      .cfg_stp  (cfg_stp[i]),
      .cfg_off  (cfg_off[i]),
      .cfg_ben  (cfg_ben[i]),
      .cfg_inf  (cfg_inf[i]),
      .cfg_bdl  (cfg_bdl[i]),
      .cfg_bil  (cfg_bil[i]),
      .cfg_bnm  (cfg_bnm[i]),
      .tbl_wen  (tbl_wen[i]),
      .tbl_addr (tbl_addr[i]),
      .tbl_dat  (tbl_dat[i]),
      .smp      (smp[i]),
      .smp_vld  (smp_vld[i]),
      .evt      (evt[i])
    );
  end

  asg_mix u_mix (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .smp     (smp),
    .smp_vld (smp_vld),
    .evt     (evt),
    .dac     (dac),
    .dac_vld (dac_vld),
    .trg_out (trg_out)
  );

endmodule : asg_top

/* bench/asg_tb.sv */
// testbench for the two-channel signal generator
// file-driven stimulus, sample model, compare tasks and watchdog

module asg_tb;

  import asg_pkg::*;

  localparam int TCK      = 40;
  localparam int WAIT_MAX = 64;
  localparam int RST_CYC  = 5;

  logic                 sto;
  logic                 ctl_rst;
  logic                 bus_wen;
  logic [AW-1:0]        bus_addr;
  logic [DW-1:0]        bus_wdata;
  logic [TN-1:0]        trg;
  logic signed [SW-1:0] dac;
  logic                 dac_vld;
  logic                 trg_out;

  // model of each channel's table and pointer
  logic signed [SW-1:0] m_tbl [NCH][2**CWM];
  logic [TN-1:0]        m_trg [NCH];
  int                   m_siz [NCH];
  int                   m_stp [NCH];
  int                   m_off [NCH];
  int                   m_bdl [NCH];
  int                   m_bnm [NCH];
  bit                   m_ben [NCH];
  bit                   m_inf [NCH];
  bit                   m_act [NCH];
  int                   m_ptr [NCH];
  int                   m_left [NCH];
  int                   m_reps [NCH];

  int          ncyc;
  int          trg_cyc;
  int          pulse_cnt;
  bit          pending_first;
  logic [31:0] lfsr;
  int          budget;

  asg_top dut0 (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .bus_wen   (bus_wen),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .trg       (trg),
    .dac       (dac),
    .dac_vld   (dac_vld),
    .trg_out   (trg_out)
  );

  always #(TCK/2) sto = ~sto;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic stop_fail();
    $display("Regression failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic compare_dac(input string name, input logic signed [SW-1:0] got,
                             input logic signed [SW-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_fail();
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_fail();
    end
  endtask

  task automatic model_start(input int c);
    m_act[c]  = 1'b1;
    m_ptr[c]  = m_off[c];
    m_left[c] = m_bdl[c] + 1;
    m_reps[c] = m_bnm[c];
  endtask

  // next mixed sample from the table model, pointer rule per channel
  task automatic model_next(output logic signed [SW-1:0] v);
    int sum;
    int s;
    int nxt;
    sum = 0;
    for (int c = 0; c < NCH; c++) begin
      if (m_act[c]) begin
        s   = m_tbl[c][(m_ptr[c] >> CWF) & (2**CWM - 1)];
        sum = sum + s;
        nxt = m_ptr[c] + m_stp[c];
        if (nxt - m_siz[c] - 1 >= 0) begin
          m_ptr[c] = (nxt - m_siz[c] - 1) & 16'hffff;
        end else begin
          m_ptr[c] = nxt & 16'hffff;
        end
        if (m_ben[c]) begin
          m_left[c] = m_left[c] - 1;
          if (m_left[c] == 0) begin
            if (m_inf[c] || m_reps[c] > 1) begin
              if (!m_inf[c]) begin
                m_reps[c] = m_reps[c] - 1;
              end
              m_ptr[c]  = m_off[c];
              m_left[c] = m_bdl[c] + 1;
            end else begin
              m_act[c] = 1'b0;
            end
          end
        end
      end
    end
    // clamp to the sample range
    if (sum > 2**(SW-1) - 1) begin
      sum = 2**(SW-1) - 1;
    end else if (sum < -(2**(SW-1))) begin
      sum = -(2**(SW-1));
    end
    v = SW'(sum);
  endtask

  ////////////////////////////////////////////////////////////
  // cycle level tasks
  ////////////////////////////////////////////////////////////

  // one cycle, outputs checked at the falling edge
  task automatic sample_cycle(output bit got);
    logic signed [SW-1:0] exp;
    bit any;
    @(negedge sto);
    ncyc = ncyc + 1;
    got  = 1'b0;
    any  = 1'b0;
    if (trg_out === 1'b1) begin
      pulse_cnt = pulse_cnt + 1;
    end
    if (dac_vld === 1'b1) begin
      for (int c = 0; c < NCH; c++) begin
        any = any | m_act[c];
      end
      if (!any) begin
        $display("dac_vld went high while no channel should be playing");
        stop_fail();
      end
      if (pending_first && (ncyc != trg_cyc + 4)) begin
        $display("first sample came %0d cycles after the trigger", ncyc - trg_cyc);
        stop_fail();
      end
      pending_first = 1'b0;
      model_next(exp);
      compare_dac("dac", dac, exp);
      got = 1'b1;
    end
  endtask

  task automatic bus_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
    bit got;
    int c;
    bit clear;
    c     = int'(addr[AW-1]);
    clear = 1'b0;
    bus_wen   = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    if (addr[AW-2]) begin
      m_tbl[c][addr[CWM-1:0]] = data[SW-1:0];
    end else begin
      case (asg_reg_e'(addr[3:0]))
        REG_CTL: begin
          m_ben[c] = data[CTL_BEN];
          m_inf[c] = data[CTL_INF];
          clear    = data[CTL_CLR];
        end
        REG_TRG: m_trg[c] = data[TN-1:0];
        REG_SIZ: m_siz[c] = int'(data[PW-1:0]);
        REG_STP: m_stp[c] = int'(data[PW-1:0]);
        REG_OFF: m_off[c] = int'(data[PW-1:0]);
        REG_BDL: m_bdl[c] = int'(data[BW-1:0]);
        REG_BNM: m_bnm[c] = int'(data[BW-1:0]);
        default: ;
      endcase
    end
    sample_cycle(got);
    bus_wen = 1'b0;
    // two samples still in flight before the clear lands
    if (clear) begin
      sample_cycle(got);
      m_act[c] = 1'b0;
    end
  endtask

  task automatic random_fill(input int c, input int n);
    logic [SW-1:0] v;
    for (int i = 0; i < n; i++) begin
      v = '0;
      repeat (SW) begin
        lfsr = lfsr_next(lfsr);
        v    = {v[SW-2:0], lfsr[0]};
      end
      bus_write(AW'((c << (AW-1)) | (1 << (AW-2)) | i), DW'(v));
    end
  endtask

  task automatic pulse_trigger(input logic [TN-1:0] mask);
    bit got;
    bit started;
    started = 1'b0;
    for (int c = 0; c < NCH; c++) begin
      if (((mask & m_trg[c]) != '0) && !m_act[c]) begin
        model_start(c);
        started = 1'b1;
      end
    end
    trg     = mask;
    trg_cyc = ncyc;
    sample_cycle(got);
    trg = '0;
    sample_cycle(got);
    compare_bit("trg_out", trg_out, started);
    if (started) begin
      pending_first = 1'b1;
    end
  endtask

  task automatic expect_samples(input int n);
    bit got;
    int k;
    int waited;
    k      = 0;
    waited = 0;
    while (k < n) begin
      sample_cycle(got);
      if (got) begin
        k = k + 1;
      end else if (k > 0) begin
        $display("dac_vld dropped after %0d of %0d samples", k, n);
        stop_fail();
      end else begin
        waited = waited + 1;
        if (waited > WAIT_MAX) begin
          $display("no valid sample arrived within %0d cycles", WAIT_MAX);
          stop_fail();
        end
      end
    end
  endtask

  task automatic expect_idle(input int n);
    bit got;
    repeat (n) begin
      sample_cycle(got);
      compare_bit("dac_vld", dac_vld, 1'b0);
      compare_dac("dac", dac, '0);
    end
  endtask

  task automatic check_pulses(input int n);
    if (pulse_cnt != n) begin
      $display("ERR trg_out pulses got %h expected %h", pulse_cnt, n);
      stop_fail();
    end
    pulse_cnt = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus file
  ////////////////////////////////////////////////////////////

  // dry pass only adds up the cycles for the watchdog
  task automatic run_file(input bit dry, output int cycles);
    int    fd;
    int    code;
    int    a;
    int    b;
    string line;
    string rest;
    byte   cmd;
    cycles = 0;
    fd = $fopen("bench/asg_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file");
      stop_fail();
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code != 0 && line.len() > 1) begin
        cmd  = line.getc(0);
        rest = line.substr(1, line.len() - 1);
        a    = 0;
        b    = 0;
        case (cmd)
          "W": begin
            code   = $sscanf(rest, "%h %h", a, b);
            cycles = cycles + 2;
            if (!dry) bus_write(AW'(a), DW'(b));
          end
          "R": begin
            code   = $sscanf(rest, "%d %d", a, b);
            cycles = cycles + 2 * b;
            if (!dry) random_fill(a, b);
          end
          "T": begin
            code   = $sscanf(rest, "%h", a);
            cycles = cycles + 4;
            if (!dry) pulse_trigger(TN'(a));
          end
          "E": begin
            code   = $sscanf(rest, "%d", a);
            cycles = cycles + a + WAIT_MAX;
            if (!dry) expect_samples(a);
          end
          "I": begin
            code   = $sscanf(rest, "%d", a);
            cycles = cycles + a;
            if (!dry) expect_idle(a);
          end
          "P": begin
            code = $sscanf(rest, "%d", a);
            if (!dry) check_pulses(a);
          end
          "#": ;
          default: begin
            $display("unknown command in the stimulus file: %s", line);
            stop_fail();
          end
        endcase
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // main
  ////////////////////////////////////////////////////////////

  initial begin
    sto           = 1'b0;
    ctl_rst       = 1'b1;
    bus_wen       = 1'b0;
    bus_addr      = '0;
    bus_wdata     = '0;
    trg           = '0;
    ncyc          = 0;
    trg_cyc       = 0;
    pulse_cnt     = 0;
    pending_first = 1'b0;
    lfsr          = 32'h42a18b8a;
    for (int c = 0; c < NCH; c++) begin
      m_trg[c] = '0;
      m_siz[c] = 0;
      m_stp[c] = 0;
      m_off[c] = 0;
      m_bdl[c] = 0;
      m_bnm[c] = 0;
      m_ben[c] = 1'b0;
      m_inf[c] = 1'b0;
      m_act[c] = 1'b0;
    end
    run_file(1'b1, budget);
    budget = budget + 4 * RST_CYC + 100;

    // watchdog
    fork
      begin
        #(budget * TCK * 2);
        $display("timeout, the run did not finish in time");
        stop_fail();
      end
    join_none

    repeat (RST_CYC) @(negedge sto);
    ctl_rst = 1'b0;
    // quiet after reset without any trigger
    expect_idle(6);
    check_pulses(0);

    run_file(1'b0, budget);

    // infinite burst with a single repetition must keep restarting
    // channel 1 masked off so only channel 0 plays
    pulse_cnt = 0;
    bus_write(AW'(1 << (AW-1)) | AW'(REG_TRG), DW'(0));
    bus_write(AW'(REG_TRG), DW'(1));
    bus_write(AW'(REG_BDL), DW'(3));
    bus_write(AW'(REG_BIL), DW'(5));
    bus_write(AW'(REG_BNM), DW'(1));
    bus_write(AW'(REG_CTL), DW'((1 << CTL_BEN) | (1 << CTL_INF)));
    pulse_trigger(TN'(1));
    repeat (3) begin
      expect_samples(4);
      // idle length plus the restart cycle
      expect_idle(6);
    end
    expect_samples(2);
    // one start and three restarts
    check_pulses(4);

    // second reset while channel 0 plays, outputs drop and stay low
    ctl_rst = 1'b1;
    repeat (RST_CYC) @(negedge sto);
    ctl_rst = 1'b0;
    for (int c = 0; c < NCH; c++) begin
      m_act[c] = 1'b0;
    end
    pulse_cnt = 0;
    expect_idle(8);
    check_pulses(0);

    $display("Regression passed");
    $finish;
  end

endmodule : asg_tb

/* bench/asg_input.txt */
# W addr data (hex) | R ch count | T mask (hex) | E samples | I idle cycles
# P trg_out pulses since last P; channel 1 registers at 8xx, tables at 4xx / Cxx
# continuous play, step 1.5, 40 entries
R 0 40
W 001 1
W 002 27FF
W 003 180
W 004 0
T 1
E 60
W 000 1
I 6
P 1
# phase, second trigger ignored
W 004 520
W 003 100
T 1
E 3
T 1
E 5
W 000 1
I 4
P 1
# finite burst, 4 samples, 6 idle, 3 times
W 005 3
W 006 5
W 007 3
W 004 0
W 000 2
T 1
E 4
I 6
E 4
I 6
E 4
I 12
P 3
# infinite burst until clear
W 000 6
T 1
E 4
I 6
E 4
I 6
E 4
W 000 1
I 8
P 3
# mixing with clamp, four-entry tables
W 000 0
W 002 3FF
W 400 7F0
W 401 800
W 402 100
W 403 F00
W 801 1
W 802 3FF
W 803 100
W 804 0
W 800 0
W C00 020
W C01 F00
W C02 050
W C03 E00
T 1
E 8
W 000 1
W 800 1
I 4
P 1

/* verilog.f */
verilog/asg_pkg.sv
verilog/asg_regs.sv
verilog/asg_channel.sv
verilog/asg_mix.sv
verilog/asg_top.sv
bench/asg_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= asg_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

test: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
